// ==== Makefile ====
# Verilator simulation of the cartridge loading front end

sim:
	verilator --binary --timing --assert --top-module tb_cart_load -f vlog.f -o sim_cart_load
	./obj_dir/sim_cart_load

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== cart_load_checker.sv ====
// Concurrent assertions for the cartridge loading front end
// Bound into the RTL top level

`timescale 1ns/1ps
`default_nettype none

module cart_load_checker (
	input wire                         clk,
	input wire                         reset_nes,
	input wire                         dl_active,
	input dl_pkg::file_index_t         dl_index,
	input wire                         dl_wr,
	input dl_pkg::code_slot_t          dl_slot,
	input wire                         mem_write,
	input nes_cart_pkg::mapper_flags_t mapper_flags,
	input wire                         load_busy,
	input wire                         load_fail,
	input wire                         machine_reset,
	input wire                         cheat_valid
);
	import dl_pkg::*;

	logic image_dl;
	logic code_last;

	assign image_dl  = dl_active && dl_index != INDEX_CHEAT;
	assign code_last = dl_active && dl_wr && dl_index == INDEX_CHEAT && dl_slot == '1;

	//////////////////////////////////////////////////
	// Memory port

	write_on_image_strobe: assert property (@(posedge clk) disable iff (reset_nes)
		mem_write |-> (image_dl && dl_wr))
		else $error("memory write without an image byte strobe");

	//////////////////////////////////////////////////
	// Supervisor outputs

	flags_zero_in_download: assert property (@(posedge clk) disable iff (reset_nes)
		image_dl |-> mapper_flags == '0)
		else $error("mapper flags nonzero during an image download");

	reset_in_download: assert property (@(posedge clk) disable iff (reset_nes)
		image_dl |-> machine_reset)
		else $error("machine reset low during an image download");

	reset_on_fail: assert property (@(posedge clk) disable iff (reset_nes)
		load_fail |-> machine_reset)
		else $error("machine reset low after a load failure");

	idle_after_reset: assert property (@(posedge clk)
		reset_nes |=> (!load_busy && !load_fail && !cheat_valid && machine_reset))
		else $error("outputs not idle after reset");

	//////////////////////////////////////////////////
	// Cheat strobe

	valid_after_last_slot: assert property (@(posedge clk) disable iff (reset_nes)
		code_last |=> cheat_valid)
		else $error("no cheat valid after slot 15");

	valid_only_after_last_slot: assert property (@(posedge clk) disable iff (reset_nes)
		cheat_valid |-> $past(code_last))
		else $error("cheat valid without a slot 15 write");

endmodule

bind cart_load_top cart_load_checker u_cart_load_checker (
	.clk           (clk),
	.reset_nes     (reset_nes),
	.dl_active     (dl_active),
	.dl_index      (dl_index),
	.dl_wr         (dl_wr),
	.dl_slot       (dl_slot),
	.mem_write     (mem_write),
	.mapper_flags  (mapper_flags),
	.load_busy     (load_busy),
	.load_fail     (load_fail),
	.machine_reset (machine_reset),
	.cheat_valid   (cheat_valid)
);

`default_nettype wire

// ==== cart_load_if.sv ====
// Interfaces between the cartridge loading blocks
// Download byte stream and loader status/control

`timescale 1ns/1ps
`default_nettype none

interface dl_stream_if;
	import nes_cart_pkg::*;
	import dl_pkg::*;

	logic       active; // High for the whole download
	logic       wr;     // One strobe per byte
	byte_t      data;
	code_slot_t slot;   // Low address bits from the host

	modport source (output active, wr, data, slot);
	modport sink   (input  active, wr, data, slot);
endinterface

interface loader_status_if;
	import nes_cart_pkg::*;

	logic          restart; // Start of a new image download
	logic          busy;
	logic          done;
	logic          error;
	mapper_flags_t flags;

	modport loader     (input  restart, output busy, done, error, flags);
	modport supervisor (output restart, input  busy, done, error, flags);
endinterface

`default_nettype wire

// ==== cart_load_top.sv ====
// Cartridge loading front end
// Splits the host download into iNES image loading and cheat code packing

`timescale 1ns/1ps
`default_nettype none

module cart_load_top #(
	parameter int DL_RESET_CYCLES = 255
) (
	input  wire                         clk,
	input  wire                         reset_nes,
	input  wire                         dl_active,
	input  dl_pkg::file_index_t         dl_index,
	input  wire                         dl_wr,
	input  nes_cart_pkg::byte_t         dl_data,
	input  dl_pkg::code_slot_t          dl_slot,
	input  wire                         invert_mirroring,
	output nes_cart_pkg::mem_addr_t     mem_addr,
	output nes_cart_pkg::byte_t         mem_data,
	output logic                        mem_write,
	output nes_cart_pkg::mapper_flags_t mapper_flags,
	output logic                        load_busy,
	output logic                        load_fail,
	output logic                        machine_reset,
	output dl_pkg::cheat_code_t         cheat_code,
	output logic                        cheat_valid
);

	dl_stream_if     rom_stream ();  // Image bytes
	dl_stream_if     code_stream (); // Cheat file bytes
	loader_status_if status ();

	load_supervisor #(
		.DL_RESET_CYCLES (DL_RESET_CYCLES)
	) u_load_supervisor (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.dl_active     (dl_active),
		.dl_index      (dl_index),
		.dl_wr         (dl_wr),
		.dl_data       (dl_data),
		.dl_slot       (dl_slot),
		.rom_stream    (rom_stream.source),
		.code_stream   (code_stream.source),
		.status        (status.supervisor),
		.mapper_flags  (mapper_flags),
		.load_busy     (load_busy),
		.load_fail     (load_fail),
		.machine_reset (machine_reset)
	);

	rom_image_loader u_rom_image_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.stream           (rom_stream.sink),
		.status           (status.loader),
		.invert_mirroring (invert_mirroring),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_write        (mem_write)
	);

	cheat_code_assembler u_cheat_code_assembler (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.stream      (code_stream.sink),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

endmodule

`default_nettype wire

// ==== cheat_code_assembler.sv ====
// Cheat code assembler
// Packs each 16 byte cheat record into a 128 bit code word

`timescale 1ns/1ps
`default_nettype none

module cheat_code_assembler (
	input  wire                 clk,
	input  wire                 reset_nes,
	dl_stream_if.sink           stream,
	output dl_pkg::cheat_code_t cheat_code,
	output logic                cheat_valid
);
	import dl_pkg::*;

	localparam code_slot_t LAST_SLOT = '1;

	logic       take;
	logic [6:0] byte_lsb;

	assign take = stream.wr & stream.active;

	// Word select from slot 3:2, top word first
	// Byte select from slot 1:0, low byte first
	assign byte_lsb = {~stream.slot[3:2], stream.slot[1:0], 3'b000};

	always_ff @(posedge clk) begin
		if (take)
			cheat_code[byte_lsb +: 8] <= stream.data;
	end

	// Code complete once slot 15 lands
	always_ff @(posedge clk) begin
		if (reset_nes)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= take && stream.slot == LAST_SLOT;
	end

endmodule

`default_nettype wire

// ==== dl_pkg.sv ====
// Host download stream and cheat code definitions

`default_nettype none

package dl_pkg;

	typedef logic [7:0]   file_index_t;  // File type chosen on the host
	typedef logic [3:0]   code_slot_t;   // Byte position inside a cheat record

	// Cheat code word
	// 127:96 flags, 95:64 address, 63:32 compare, 31:0 replace
	// Each word arrives low byte first from the host
	typedef logic [127:0] cheat_code_t;

	localparam file_index_t INDEX_CHEAT = '1;

endpackage

`default_nettype wire

// ==== load_supervisor.sv ====
// Load supervisor
// Routes the download by file type, keeps the loader results and
// holds the machine in reset around image loads

`timescale 1ns/1ps
`default_nettype none

module load_supervisor #(
	parameter int DL_RESET_CYCLES = 255
) (
	input  wire                         clk,
	input  wire                         reset_nes,
	input  wire                         dl_active,
	input  dl_pkg::file_index_t         dl_index,
	input  wire                         dl_wr,
	input  nes_cart_pkg::byte_t         dl_data,
	input  dl_pkg::code_slot_t          dl_slot,
	dl_stream_if.source                 rom_stream,
	dl_stream_if.source                 code_stream,
	loader_status_if.supervisor         status,
	output nes_cart_pkg::mapper_flags_t mapper_flags,
	output logic                        load_busy,
	output logic                        load_fail,
	output logic                        machine_reset
);
	import nes_cart_pkg::*;
	import dl_pkg::*;

	localparam int CNT_W = (DL_RESET_CYCLES > 0) ? $clog2(DL_RESET_CYCLES + 1) : 1;

	logic             is_cheat;
	logic             rom_active_q;
	logic             seen_image;  // First image download has begun
	logic             fail_q;
	logic [CNT_W-1:0] reset_cnt;
	mapper_flags_t    flags_q;

	//////////////////////////////////////////////////
	// Stream routing

	assign is_cheat = dl_index == INDEX_CHEAT;

	assign rom_stream.active  = dl_active & ~is_cheat;
	assign rom_stream.wr      = dl_wr & ~is_cheat;
	assign rom_stream.data    = dl_data;
	assign rom_stream.slot    = dl_slot;

	assign code_stream.active = dl_active & is_cheat;
	assign code_stream.wr     = dl_wr & is_cheat;
	assign code_stream.data   = dl_data;
	assign code_stream.slot   = dl_slot;

	assign status.restart = rom_stream.active & ~rom_active_q; // Rising edge of image download

	//////////////////////////////////////////////////
	// Loader results and machine reset

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			rom_active_q <= 1'b0;
			seen_image   <= 1'b0;
			fail_q       <= 1'b0;
			flags_q      <= '0;
			reset_cnt    <= '0;
		end else begin
			rom_active_q <= rom_stream.active;
			if (rom_stream.active)
				seen_image <= 1'b1;
			if (status.restart)
				fail_q <= 1'b0;
			else if (status.done) begin
				fail_q  <= status.error;
				flags_q <= status.flags;
			end
			if (rom_stream.active)
				reset_cnt <= CNT_W'(DL_RESET_CYCLES);
			else if (!status.busy && reset_cnt != '0)
				reset_cnt <= reset_cnt - 1'b1; // Counts only once the loader is idle
		end
	end

	assign mapper_flags  = rom_stream.active ? '0 : flags_q;
	assign load_busy     = status.busy;
	assign load_fail     = fail_q;
	assign machine_reset = ~seen_image | rom_stream.active | fail_q | (reset_cnt != '0);

endmodule

`default_nettype wire

// ==== nes_cart_pkg.sv ====
// iNES cartridge format definitions
// Field widths, header magic, memory map and the mapper flags word layout

`default_nettype none

package nes_cart_pkg;

	typedef logic [7:0]  byte_t;         // One stream or memory byte
	typedef logic [21:0] mem_addr_t;     // Cartridge memory address
	typedef logic [7:0]  page_count_t;   // PRG or CHR page count from header
	typedef logic [2:0]  size_code_t;    // Log2 size code of a ROM region
	typedef logic [31:0] mapper_flags_t; // Flags word handed to the machine
	typedef logic [21:0] byte_count_t;   // Bytes left in the current region

	//////////////////////////////////////////////////
	// Header layout

	localparam int unsigned HEADER_BYTES = 16;

	localparam byte_t MAGIC_0 = 8'h4E; // N
	localparam byte_t MAGIC_1 = 8'h45; // E
	localparam byte_t MAGIC_2 = 8'h53; // S
	localparam byte_t MAGIC_3 = 8'h1A;

	localparam int unsigned TRAINER_BIT = 2;       // Byte 6, trainer present
	localparam logic [1:0]  NES20_ID    = 2'b10;   // Byte 7 bits 3:2

	//////////////////////////////////////////////////
	// Memory map

	localparam int unsigned PRG_PAGE_BYTES = 16384;
	localparam int unsigned CHR_PAGE_BYTES = 8192;

	localparam mem_addr_t PRG_BASE = 22'h000000;
	localparam mem_addr_t CHR_BASE = 22'h200000;

	//////////////////////////////////////////////////
	// Mapper flags word, bit positions
	// Bits 31:26 are always zero

	localparam int unsigned FLAG_MAPPER_LSB    = 0;  // 8 bit mapper number
	localparam int unsigned FLAG_PRG_SIZE_LSB  = 8;  // 3 bit PRG size code
	localparam int unsigned FLAG_CHR_SIZE_LSB  = 11; // 3 bit CHR size code
	localparam int unsigned FLAG_MIRRORING     = 14;
	localparam int unsigned FLAG_CHR_RAM       = 15;
	localparam int unsigned FLAG_FOUR_SCREEN   = 16;
	localparam int unsigned FLAG_SUBMAPPER_LSB = 17; // NES 2.0 byte 8
	localparam int unsigned FLAG_HAS_SAVES     = 25;

endpackage

`default_nettype wire

// ==== rom_image_loader.sv ====
// iNES image loader
// Captures and checks the 16 byte header, builds the mapper flags word,
// then writes PRG and CHR bytes to the cartridge memory port

`timescale 1ns/1ps
`default_nettype none

module rom_image_loader (
	input  wire                     clk,
	input  wire                     reset_nes,
	dl_stream_if.sink               stream,
	loader_status_if.loader         status,
	input  wire                     invert_mirroring,
	output nes_cart_pkg::mem_addr_t mem_addr,
	output nes_cart_pkg::byte_t     mem_data,
	output logic                    mem_write
);
	import nes_cart_pkg::*;

	typedef enum logic [2:0] {
		S_HEADER,
		S_PRG,
		S_CHR,
		S_ERROR,
		S_DONE
	} state_t;

	localparam logic [3:0] LAST_HDR = 4'(HEADER_BYTES - 1);

	state_t        state;
	byte_t         header [HEADER_BYTES];
	logic [3:0]    hdr_ctr;
	logic [3:0]    hdr_idx;
	logic          hdr_we;
	byte_count_t   bytes_left;
	byte_count_t   prg_bytes;
	byte_count_t   chr_bytes;
	logic          take;
	logic          header_ok;
	logic          is_nes20;
	logic          tail_dirty;
	logic          is_dirty;
	logic          phase_end;
	mapper_flags_t flags_c;

	// Smallest k with pages <= 2^k, 7 past 64 pages
	function automatic size_code_t size_code(input page_count_t pages);
		size_code_t code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if (int'(pages) <= (1 << k))
				code = size_code_t'(k);
		end
		return code;
	endfunction

	assign take = stream.wr & stream.active;

	//////////////////////////////////////////////////
	// Header capture

	assign hdr_idx = status.restart ? 4'd0 : hdr_ctr; // First byte may share the restart cycle
	assign hdr_we  = take && (status.restart || state == S_HEADER);

	always_ff @(posedge clk) begin
		if (hdr_we)
			header[hdr_idx] <= stream.data;
	end

	assign header_ok = header[0] == MAGIC_0 && header[1] == MAGIC_1 &&
	                   header[2] == MAGIC_2 && header[3] == MAGIC_3 &&
	                   !header[6][TRAINER_BIT];

	assign prg_bytes = byte_count_t'(header[4] * PRG_PAGE_BYTES);
	assign chr_bytes = byte_count_t'(header[5] * CHR_PAGE_BYTES);

	//////////////////////////////////////////////////
	// Header decode

	assign is_nes20 = header[7][3:2] == NES20_ID;

	always_comb begin
		tail_dirty = |header[9][7:1];
		for (int i = 10; i < HEADER_BYTES; i++)
			tail_dirty = tail_dirty | (|header[i]);
	end

	assign is_dirty = !is_nes20 && tail_dirty; // Junk in old iNES 1.0 dumps

	always_comb begin
		flags_c = '0;
		flags_c[FLAG_MAPPER_LSB +: 8]    = {is_dirty ? 4'h0 : header[7][7:4], header[6][7:4]};
		flags_c[FLAG_PRG_SIZE_LSB +: 3]  = size_code(header[4]);
		flags_c[FLAG_CHR_SIZE_LSB +: 3]  = size_code(header[5]);
		flags_c[FLAG_MIRRORING]          = header[6][0] ^ invert_mirroring;
		flags_c[FLAG_CHR_RAM]            = header[5] == 8'h00;
		flags_c[FLAG_FOUR_SCREEN]        = header[6][3];
		flags_c[FLAG_SUBMAPPER_LSB +: 8] = is_nes20 ? header[8] : 8'h00;
		flags_c[FLAG_HAS_SAVES]          = header[6][1];
	end

	assign status.flags = flags_c;

	//////////////////////////////////////////////////
	// PRG / CHR write sequencer

	assign mem_data  = stream.data;
	assign mem_write = take && !status.restart && bytes_left != '0 &&
	                   (state == S_PRG || state == S_CHR);

	// Region finishes on its last byte, or at once when it is empty
	assign phase_end = bytes_left == '0 || (mem_write && bytes_left == 22'd1);

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state        <= S_HEADER;
			hdr_ctr      <= '0;
			bytes_left   <= '0;
			mem_addr     <= PRG_BASE;
			status.busy  <= 1'b0;
			status.done  <= 1'b0;
			status.error <= 1'b0;
		end else if (status.restart) begin
			state        <= S_HEADER;
			hdr_ctr      <= take ? 4'd1 : 4'd0;
			status.busy  <= 1'b0;
			status.done  <= 1'b0;
			status.error <= 1'b0;
		end else begin
			case (state)
				S_HEADER: if (take) begin
					hdr_ctr <= hdr_ctr + 1'b1;
					if (hdr_ctr == LAST_HDR) begin
						if (header_ok) begin
							state       <= S_PRG;
							status.busy <= 1'b1;
							bytes_left  <= prg_bytes;
							mem_addr    <= PRG_BASE;
						end else begin
							state        <= S_ERROR; // Bad magic or trainer
							status.done  <= 1'b1;
							status.error <= 1'b1;
						end
					end
				end
				S_PRG, S_CHR: begin
					if (mem_write) begin
						bytes_left <= bytes_left - 1'b1;
						mem_addr   <= mem_addr + 1'b1;
					end
					if (phase_end) begin
						if (state == S_PRG) begin
							state      <= S_CHR;
							mem_addr   <= CHR_BASE;
							bytes_left <= chr_bytes;
						end else begin
							state       <= S_DONE;
							status.done <= 1'b1;
							status.busy <= 1'b0;
						end
					end
				end
				default: ; // Error and done wait for the next restart
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== tb_cart_load.sv ====
// Testbench for the cartridge loading front end
// Sends iNES images, a bad image and a cheat file, checks writes, flags and resets

`timescale 1ns/1ps
`default_nettype none

module tb_cart_load;
	import nes_cart_pkg::*;
	import dl_pkg::*;

	localparam int DL_RESET_CYCLES = 20;
	localparam int PAYLOAD_BYTES   = PRG_PAGE_BYTES + CHR_PAGE_BYTES; // One page of each
	localparam int BAD_TAIL_BYTES  = 64;
	// Two good images, the bad one, a cheat file and the reset waits, plus slack
	localparam int WATCHDOG_CYCLES = 2 * (HEADER_BYTES + PAYLOAD_BYTES) + HEADER_BYTES +
	                                 BAD_TAIL_BYTES + 16 + 3 * DL_RESET_CYCLES + 200;

	logic          clk;
	logic          reset_nes;
	logic          dl_active;
	file_index_t   dl_index;
	logic          dl_wr;
	byte_t         dl_data;
	code_slot_t    dl_slot;
	logic          invert_mirroring;
	mem_addr_t     mem_addr;
	byte_t         mem_data;
	logic          mem_write;
	mapper_flags_t mapper_flags;
	logic          load_busy;
	logic          load_fail;
	logic          machine_reset;
	cheat_code_t   cheat_code;
	logic          cheat_valid;

	integer seed;
	int     write_count;
	byte_t  header [HEADER_BYTES];

	cart_load_top #(
		.DL_RESET_CYCLES (DL_RESET_CYCLES)
	) u_cart_load_top (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.dl_active        (dl_active),
		.dl_index         (dl_index),
		.dl_wr            (dl_wr),
		.dl_data          (dl_data),
		.dl_slot          (dl_slot),
		.invert_mirroring (invert_mirroring),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_write        (mem_write),
		.mapper_flags     (mapper_flags),
		.load_busy        (load_busy),
		.load_fail        (load_fail),
		.machine_reset    (machine_reset),
		.cheat_code       (cheat_code),
		.cheat_valid      (cheat_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(negedge clk) begin
		if (reset_nes)
			write_count <= 0;
		else if (mem_write)
			write_count <= write_count + 1;
	end

	//////////////////////////////////////////////////
	// Checks and reporting

	task automatic report_mismatch(input string name, input logic [127:0] expected,
	                               input logic [127:0] actual);
		$display("error %s: expected %0h, actual %0h", name, expected, actual);
		$display("CHECKS FAILED");
		$fatal(1, "mismatch in %s", name);
	endtask

	task automatic expect_value(input string name, input logic [127:0] expected,
	                            input logic [127:0] actual);
		assert (actual === expected)
		else report_mismatch(name, expected, actual);
	endtask

	task automatic expect_bit(input string name, input logic expected, input logic actual);
		assert (actual === expected)
		else report_mismatch(name, 128'(expected), 128'(actual));
	endtask

	//////////////////////////////////////////////////
	// Expected mapper flags

	function automatic logic [2:0] size_code_of(input int pages);
		logic [2:0] code;
		bit         found;
		code  = 3'd7;
		found = 1'b0;
		for (int k = 0; k < 7; k++) begin
			if (!found && pages <= (1 << k)) begin
				code  = 3'(k);
				found = 1'b1;
			end
		end
		return code;
	endfunction

	function automatic mapper_flags_t expected_flags(input logic inv);
		logic       nes20;
		logic       dirty;
		logic [3:0] mapper_hi;
		logic [7:0] submapper;
		nes20 = header[7][3:2] == 2'b10;
		dirty = 1'b0;
		if (!nes20) begin
			dirty = |header[9][7:1];
			for (int i = 10; i < 16; i++)
				if (header[i] != 8'h00)
					dirty = 1'b1;
		end
		mapper_hi = dirty ? 4'h0 : header[7][7:4];
		submapper = nes20 ? header[8] : 8'h00;
		return {6'b0, header[6][1], submapper, header[6][3], header[5] == 8'h00,
		        header[6][0] ^ inv, size_code_of(int'(header[5])),
		        size_code_of(int'(header[4])), mapper_hi, header[6][7:4]};
	endfunction

	//////////////////////////////////////////////////
	// Stimulus

	task automatic make_header(input bit nes20, input bit good_magic);
		for (int i = 0; i < HEADER_BYTES; i++)
			header[i] = byte_t'($random(seed));
		header[0] = good_magic ? MAGIC_0 : 8'h00;
		header[1] = MAGIC_1;
		header[2] = MAGIC_2;
		header[3] = MAGIC_3;
		header[4] = 8'd1;
		header[5] = 8'd1;
		header[6][2] = 1'b0;     // No trainer
		header[7][3:2] = nes20 ? 2'b10 : 2'b00;
		if (!nes20)
			header[15][0] = 1'b1; // Force a dirty tail
	endtask

	task automatic start_download(input file_index_t index, input logic inv);
		@(posedge clk);
		dl_active        <= 1'b1;
		dl_index         <= index;
		invert_mirroring <= inv;
		@(negedge clk);
	endtask

	task automatic send_byte(input byte_t b, input code_slot_t slot);
		@(posedge clk);
		dl_wr   <= 1'b1;
		dl_data <= b;
		dl_slot <= slot;
		@(negedge clk);
	endtask

	task automatic end_download();
		@(posedge clk);
		dl_wr     <= 1'b0;
		dl_active <= 1'b0;
		@(negedge clk);
	endtask

	task automatic send_header();
		for (int i = 0; i < HEADER_BYTES; i++) begin
			send_byte(header[i], 4'(i));
			expect_bit("header no write", 1'b0, mem_write);
			expect_value("flags in download", '0, 128'(mapper_flags));
			expect_bit("reset in download", 1'b1, machine_reset);
		end
	endtask

	task automatic send_image(input logic inv);
		int        base;
		byte_t     b;
		mem_addr_t addr;
		start_download(8'h01, inv);
		base = write_count;
		send_header();
		for (int i = 0; i < PAYLOAD_BYTES; i++) begin
			b    = byte_t'($random(seed));
			addr = (i < PRG_PAGE_BYTES) ? PRG_BASE + mem_addr_t'(i) :
			                              CHR_BASE + mem_addr_t'(i - PRG_PAGE_BYTES);
			send_byte(b, 4'(i));
			expect_bit("payload write", 1'b1, mem_write);
			expect_bit("loader busy", 1'b1, load_busy);
			expect_value("write address", 128'(addr), 128'(mem_addr));
			expect_value("write data", 128'(b), 128'(mem_data));
		end
		end_download();
		expect_value("write count", 128'(base + PAYLOAD_BYTES), 128'(write_count));
	endtask

	// Runs right after end_download, one negedge past the inactive edge
	task automatic check_post_load(input mapper_flags_t flags);
		expect_bit("loader idle", 1'b0, load_busy);
		expect_bit("post load reset", 1'b1, machine_reset);
		for (int i = 1; i < DL_RESET_CYCLES; i++) begin
			@(negedge clk);
			expect_bit("post load reset", 1'b1, machine_reset);
		end
		@(negedge clk);
		expect_bit("reset release", 1'b0, machine_reset);
		expect_bit("load fail", 1'b0, load_fail);
		expect_value("mapper flags", 128'(flags), 128'(mapper_flags));
	endtask

	task automatic send_cheat();
		cheat_code_t code;
		byte_t       b;
		int          base;
		code = '0;
		start_download(INDEX_CHEAT, invert_mirroring);
		base = write_count;
		for (int s = 0; s < 16; s++) begin
			b = byte_t'($random(seed));
			code[96 - 32 * (s / 4) + 8 * (s % 4) +: 8] = b; // Top word first
			send_byte(b, 4'(s));
			expect_bit("cheat valid early", 1'b0, cheat_valid);
		end
		end_download();
		expect_bit("cheat valid", 1'b1, cheat_valid);
		expect_value("cheat code", code, cheat_code);
		@(negedge clk);
		expect_bit("cheat valid width", 1'b0, cheat_valid);
		expect_value("cheat write count", 128'(base), 128'(write_count));
	endtask

	task automatic send_bad_image();
		int base;
		make_header(1'b0, 1'b0);
		start_download(8'h01, invert_mirroring);
		base = write_count;
		send_header();
		for (int i = 0; i < BAD_TAIL_BYTES; i++) begin
			send_byte(byte_t'($random(seed)), 4'(i));
			expect_bit("bad image write", 1'b0, mem_write);
		end
		expect_bit("bad magic fail", 1'b1, load_fail);
		end_download();
		repeat (DL_RESET_CYCLES + 4) begin
			@(negedge clk);
			expect_bit("reset on fail", 1'b1, machine_reset);
		end
		expect_value("bad image write count", 128'(base), 128'(write_count));
	endtask

	initial begin
		seed             = 9;
		reset_nes        <= 1'b1;
		dl_active        <= 1'b0;
		dl_index         <= 8'h00;
		dl_wr            <= 1'b0;
		dl_data          <= 8'h00;
		dl_slot          <= 4'h0;
		invert_mirroring <= 1'b0;
		repeat (5) @(posedge clk);
		reset_nes <= 1'b0;
		repeat (3) begin
			@(negedge clk);
			expect_bit("reset mem_write", 1'b0, mem_write);
			expect_bit("reset cheat_valid", 1'b0, cheat_valid);
			expect_bit("reset machine_reset", 1'b1, machine_reset);
		end

		make_header(1'b0, 1'b1);   // Dirty iNES 1.0
		send_image(1'b1);
		check_post_load(expected_flags(1'b1));

		send_cheat();
		send_bad_image();

		make_header(1'b1, 1'b1);   // NES 2.0 with submapper
		send_image(1'b0);
		check_post_load(expected_flags(1'b0));

		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: run went past %0d clock cycles", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
nes_cart_pkg.sv
dl_pkg.sv
cart_load_if.sv
rom_image_loader.sv
cheat_code_assembler.sv
load_supervisor.sv
cart_load_top.sv
cart_load_checker.sv
tb_cart_load.sv
